// File: hw/pci_pkg.sv
package pci_pkg;

  // Widths with a meaning on the UART, the bus and the core
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;
  typedef logic [7:0]  waddr_t;
  typedef logic [3:0]  opcode_t;

  // Host command bytes
  localparam byte_t CMD_WRITE  = 8'h57;
  localparam byte_t CMD_READ   = 8'h52;
  localparam byte_t CMD_START  = 8'h53;
  localparam byte_t CMD_HALT   = 8'h48;
  localparam byte_t CMD_STATUS = 8'h51;

  // Core opcodes, carried in instruction bits 31..28
  localparam opcode_t OP_LOADI = 4'd0;
  localparam opcode_t OP_ADDI  = 4'd1;
  localparam opcode_t OP_STORE = 4'd2;
  localparam opcode_t OP_HALT  = 4'd3;

endpackage

// File: hw/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
  parameter int CLK_FREQ = 25_000_000,
  parameter int BIT_RATE = 2_500_000
) (
  input  logic           sys_clk,
  input  logic           arst_n_i,
  input  logic           rx_i,
  output logic           valid_o,
  output pci_pkg::byte_t data_o
);
  import pci_pkg::*;

  localparam int CLKS_PER_BIT = CLK_FREQ / BIT_RATE;
  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

  state_t           state;
  logic [1:0]       rx_sync;
  logic             rx_s;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  byte_t            shift;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rx_i};
    end
  end

  assign rx_s = rx_sync[1];

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state   <= IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      case (state)
        IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!rx_s) begin
            state <= START;
          end
        end
        START: begin
          // Recheck in the middle of the start bit to reject glitches
          if (clk_cnt == HALF_BIT) begin
            clk_cnt <= '0;
            state   <= rx_s ? IDLE : DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        DATA: begin
          if (clk_cnt == FULL_BIT) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        STOP: begin
          if (clk_cnt == FULL_BIT) begin
            // Framing error drops the byte
            valid_o <= rx_s;
            state   <= IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // LSB first, sampled mid-bit
  always_ff @(posedge sys_clk) begin
    if (state == DATA && clk_cnt == FULL_BIT) begin
      shift <= {rx_s, shift[7:1]};
    end
  end

  assign data_o = shift;

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
  parameter int CLK_FREQ = 25_000_000,
  parameter int BIT_RATE = 2_500_000
) (
  input  logic           sys_clk,
  input  logic           arst_n_i,
  input  logic           start_i,
  input  pci_pkg::byte_t data_i,
  output logic           busy_o,
  output logic           tx_o
);
  import pci_pkg::*;

  localparam int CLKS_PER_BIT = CLK_FREQ / BIT_RATE;
  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;
  logic [8:0]       shift;
  logic             bit_end;

  assign bit_end = busy_o && (clk_cnt == FULL_BIT);

  // Bit 0 is the start bit, 1 to 8 carry data, 9 is the stop bit
  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_o  <= 1'b0;
      tx_o    <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (!busy_o) begin
      clk_cnt <= '0;
      bit_idx <= '0;
      if (start_i) begin
        busy_o <= 1'b1;
        tx_o   <= 1'b0;
      end
    end else if (!bit_end) begin
      clk_cnt <= clk_cnt + 1'b1;
    end else begin
      clk_cnt <= '0;
      if (bit_idx == 4'd9) begin
        busy_o <= 1'b0;
      end else begin
        tx_o    <= shift[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end
  end

  // Stop bit rides above the data byte
  always_ff @(posedge sys_clk) begin
    if (!busy_o && start_i) begin
      shift <= {1'b1, data_i};
    end else if (bit_end) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule

// File: hw/cmd_decoder.sv
`timescale 1ns/1ns

module cmd_decoder (
  input  logic            sys_clk,
  input  logic            arst_n_i,
  input  logic            rx_valid_i,
  input  pci_pkg::byte_t  rx_byte_i,
  input  logic            tx_busy_i,
  output logic            tx_start_o,
  output pci_pkg::byte_t  tx_byte_o,
  output logic            host_we_o,
  output logic            host_re_o,
  output pci_pkg::waddr_t host_addr_o,
  output pci_pkg::word_t  host_wdata_o,
  input  pci_pkg::word_t  host_rdata_i,
  input  logic            core_halted_i,
  output logic            core_run_o
);
  import pci_pkg::*;

  typedef enum logic [2:0] {IDLE, ADDR, DATA, RD_WAIT, RD_CAPTURE, REPLY} state_t;

  state_t     state;
  byte_t      cmd_q;
  logic [1:0] byte_cnt;
  logic [1:0] reply_cnt;
  waddr_t     addr_q;
  word_t      wdata_q;
  word_t      reply_q;
  logic       tx_idle;
  logic       rx_take;

  // Transmitter free, including the cycle of our own start pulse
  assign tx_idle = !tx_busy_i && !tx_start_o;
  // Bytes arriving during a reply are dropped
  assign rx_take = rx_valid_i && tx_idle;

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state      <= IDLE;
      cmd_q      <= '0;
      byte_cnt   <= '0;
      reply_cnt  <= '0;
      host_we_o  <= 1'b0;
      host_re_o  <= 1'b0;
      tx_start_o <= 1'b0;
      core_run_o <= 1'b0;
    end else begin
      host_we_o  <= 1'b0;
      host_re_o  <= 1'b0;
      tx_start_o <= 1'b0;
      case (state)
        IDLE: begin
          if (rx_take) begin
            case (rx_byte_i)
              CMD_WRITE, CMD_READ: begin
                cmd_q <= rx_byte_i;
                state <= ADDR;
              end
              CMD_START: core_run_o <= 1'b1;
              CMD_HALT:  core_run_o <= 1'b0;
              CMD_STATUS: begin
                reply_cnt <= 2'd0;
                state     <= REPLY;
              end
              default: ;
            endcase
          end
        end
        ADDR: begin
          if (rx_take) begin
            byte_cnt <= '0;
            if (cmd_q == CMD_WRITE) begin
              state <= DATA;
            end else begin
              host_re_o <= 1'b1;
              state     <= RD_WAIT;
            end
          end
        end
        DATA: begin
          if (rx_take) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) begin
              host_we_o <= 1'b1;
              state     <= IDLE;
            end
          end
        end
        // Memory registers the word during this cycle
        RD_WAIT: state <= RD_CAPTURE;
        RD_CAPTURE: begin
          reply_cnt <= 2'd3;
          state     <= REPLY;
        end
        REPLY: begin
          if (tx_idle) begin
            tx_start_o <= 1'b1;
            if (reply_cnt == 2'd0) begin
              state <= IDLE;
            end else begin
              reply_cnt <= reply_cnt - 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address, write data and reply shifter, all LSB first
  always_ff @(posedge sys_clk) begin
    if (state == ADDR && rx_take) begin
      addr_q <= rx_byte_i;
    end
    if (state == DATA && rx_take) begin
      wdata_q <= {rx_byte_i, wdata_q[31:8]};
    end
    if (state == IDLE && rx_take && rx_byte_i == CMD_STATUS) begin
      reply_q <= {30'd0, core_halted_i, core_run_o};
    end else if (state == RD_CAPTURE) begin
      reply_q <= host_rdata_i;
    end else if (state == REPLY && tx_idle) begin
      tx_byte_o <= reply_q[7:0];
      reply_q   <= reply_q >> 8;
    end
  end

  assign host_addr_o  = addr_q;
  assign host_wdata_o = wdata_q;

endmodule

// File: hw/prog_memory.sv
`timescale 1ns/1ns

module prog_memory #(
  parameter int MEM_WORDS = 64
) (
  input  logic            sys_clk,
  input  logic            arst_n_i,
  input  logic            host_we_i,
  input  logic            host_re_i,
  input  pci_pkg::waddr_t host_addr_i,
  input  pci_pkg::word_t  host_wdata_i,
  output pci_pkg::word_t  host_rdata_o,
  input  logic            bus_cyc_i,
  input  logic            bus_stb_i,
  input  logic            bus_we_i,
  input  pci_pkg::waddr_t bus_addr_i,
  input  pci_pkg::word_t  bus_wdata_i,
  output pci_pkg::word_t  bus_rdata_o,
  output logic            bus_ack_o
);
  import pci_pkg::*;

  localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  word_t         mem [MEM_WORDS];
  logic [AW-1:0] host_idx;
  logic [AW-1:0] bus_idx;
  logic          bus_req;

  assign host_idx = host_addr_i[AW-1:0];
  assign bus_idx  = bus_addr_i[AW-1:0];

  // New request only, so a held strobe is not acked twice
  assign bus_req = bus_cyc_i && bus_stb_i && !bus_ack_o;

  always_ff @(posedge sys_clk) begin
    if (host_we_i) begin
      mem[host_idx] <= host_wdata_i;
    end
    // Core port last, it wins a same-word collision
    if (bus_req && bus_we_i) begin
      mem[bus_idx] <= bus_wdata_i;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (host_re_i) begin
      host_rdata_o <= mem[host_idx];
    end
    if (bus_req && !bus_we_i) begin
      bus_rdata_o <= mem[bus_idx];
    end
  end

  // Ack one cycle after the strobe is seen
  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus_ack_o <= 1'b0;
    end else begin
      bus_ack_o <= bus_req;
    end
  end

endmodule

// File: hw/acc_core.sv
`timescale 1ns/1ns

module acc_core (
  input  logic            sys_clk,
  input  logic            arst_n_i,
  input  logic            run_i,
  output logic            halted_o,
  output logic            cyc_o,
  output logic            stb_o,
  output logic            we_o,
  output pci_pkg::waddr_t addr_o,
  output pci_pkg::word_t  wdata_o,
  input  pci_pkg::word_t  rdata_i,
  input  logic            ack_i
);
  import pci_pkg::*;

  typedef enum logic [2:0] {IDLE, FETCH, EXEC, STORE, HALTED} state_t;

  state_t  state;
  waddr_t  pc;
  word_t   acc;
  word_t   ir;
  opcode_t op;
  byte_t   imm;

  assign op  = ir[31:28];
  assign imm = ir[7:0];

  // Bus requests decoded from the state register
  assign cyc_o   = (state == FETCH) || (state == STORE);
  assign stb_o   = cyc_o;
  assign we_o    = (state == STORE);
  assign addr_o  = (state == STORE) ? imm : pc;
  assign wdata_o = acc;

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state    <= IDLE;
      pc       <= '0;
      acc      <= '0;
      halted_o <= 1'b0;
    end else if (!run_i) begin
      // Run level low parks the core at address 0
      state    <= IDLE;
      pc       <= '0;
      acc      <= '0;
      halted_o <= 1'b0;
    end else begin
      case (state)
        IDLE: state <= FETCH;
        FETCH: begin
          if (ack_i) begin
            state <= EXEC;
          end
        end
        EXEC: begin
          case (op)
            OP_LOADI: begin
              acc   <= {24'd0, imm};
              pc    <= pc + 1'b1;
              state <= FETCH;
            end
            OP_ADDI: begin
              acc   <= acc + {24'd0, imm};
              pc    <= pc + 1'b1;
              state <= FETCH;
            end
            OP_STORE: state <= STORE;
            OP_HALT: begin
              halted_o <= 1'b1;
              state    <= HALTED;
            end
            // Unknown opcodes just step
            default: begin
              pc    <= pc + 1'b1;
              state <= FETCH;
            end
          endcase
        end
        STORE: begin
          // Next fetch follows back to back
          if (ack_i) begin
            pc    <= pc + 1'b1;
            state <= FETCH;
          end
        end
        HALTED: ;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == FETCH && ack_i) begin
      ir <= rdata_i;
    end
  end

endmodule

// File: hw/processorci_top.sv
`timescale 1ns/1ns

module processorci_top #(
  parameter int CLK_FREQ  = 25_000_000,
  parameter int BIT_RATE  = 2_500_000,
  parameter int MEM_WORDS = 64
) (
  input  logic sys_clk,
  input  logic arst_n_i,
  input  logic rx_i,
  output logic tx_o,
  output logic halted_o
);
  import pci_pkg::*;

  // Host side
  logic   rx_valid;
  byte_t  rx_byte;
  logic   tx_start;
  byte_t  tx_byte;
  logic   tx_busy;
  logic   host_we;
  logic   host_re;
  waddr_t host_addr;
  word_t  host_wdata;
  word_t  host_rdata;
  logic   core_run;

  // Core bus
  logic   bus_cyc;
  logic   bus_stb;
  logic   bus_we;
  waddr_t bus_addr;
  word_t  bus_wdata;
  word_t  bus_rdata;
  logic   bus_ack;

  uart_rx #(
    .CLK_FREQ (CLK_FREQ),
    .BIT_RATE (BIT_RATE)
  ) uart_rx_inst (
    .sys_clk  (sys_clk),
    .arst_n_i (arst_n_i),
    .rx_i     (rx_i),
    .valid_o  (rx_valid),
    .data_o   (rx_byte)
  );

  cmd_decoder cmd_decoder_inst (
    .sys_clk       (sys_clk),
    .arst_n_i      (arst_n_i),
    .rx_valid_i    (rx_valid),
    .rx_byte_i     (rx_byte),
    .tx_busy_i     (tx_busy),
    .tx_start_o    (tx_start),
    .tx_byte_o     (tx_byte),
    .host_we_o     (host_we),
    .host_re_o     (host_re),
    .host_addr_o   (host_addr),
    .host_wdata_o  (host_wdata),
    .host_rdata_i  (host_rdata),
    .core_halted_i (halted_o),
    .core_run_o    (core_run)
  );

  uart_tx #(
    .CLK_FREQ (CLK_FREQ),
    .BIT_RATE (BIT_RATE)
  ) uart_tx_inst (
    .sys_clk  (sys_clk),
    .arst_n_i (arst_n_i),
    .start_i  (tx_start),
    .data_i   (tx_byte),
    .busy_o   (tx_busy),
    .tx_o     (tx_o)
  );

  prog_memory #(
    .MEM_WORDS (MEM_WORDS)
  ) prog_memory_inst (
    .sys_clk      (sys_clk),
    .arst_n_i     (arst_n_i),
    .host_we_i    (host_we),
    .host_re_i    (host_re),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_rdata_o (host_rdata),
    .bus_cyc_i    (bus_cyc),
    .bus_stb_i    (bus_stb),
    .bus_we_i     (bus_we),
    .bus_addr_i   (bus_addr),
    .bus_wdata_i  (bus_wdata),
    .bus_rdata_o  (bus_rdata),
    .bus_ack_o    (bus_ack)
  );

  acc_core acc_core_inst (
    .sys_clk  (sys_clk),
    .arst_n_i (arst_n_i),
    .run_i    (core_run),
    .halted_o (halted_o),
    .cyc_o    (bus_cyc),
    .stb_o    (bus_stb),
    .we_o     (bus_we),
    .addr_o   (bus_addr),
    .wdata_o  (bus_wdata),
    .rdata_i  (bus_rdata),
    .ack_i    (bus_ack)
  );

endmodule

// File: test/tb_processorci.sv
`timescale 1ns/1ns

module tb_processorci;
  import pci_pkg::*;

  localparam int CLK_FREQ     = 25_000_000;
  localparam int BIT_RATE     = 2_500_000;
  localparam int MEM_WORDS    = 64;
  localparam int CLKS_PER_BIT = CLK_FREQ / BIT_RATE;
  localparam int NUM_RW       = 20;
  localparam int PROG_LEN     = 12;
  localparam int QUIET_BYTES  = 3;

  // Bytes on both UART lines over all tests, stored reads counted at their maximum
  localparam int UART_BYTES = 2 + NUM_RW * 12
                            + (PROG_LEN * 6 + 3 + PROG_LEN * 6)
                            + (3 + PROG_LEN * 6 + 3 + PROG_LEN * 6)
                            + (1 + QUIET_BYTES + 6);
  localparam int PROG_CYCLES    = 2 * (PROG_LEN * 5 + 2);
  localparam int TIMEOUT_CYCLES = (UART_BYTES * 10 * CLKS_PER_BIT + PROG_CYCLES) * 2;

  logic sys_clk;
  logic arst_n_i;
  logic rx_i;
  logic tx_o;
  logic halted_o;

  word_t  model_mem [MEM_WORDS];
  bit     store_hit [MEM_WORDS];
  waddr_t wr_addr [NUM_RW];
  byte_t  reply_q [$];
  int     cycle_cnt = 0;

  processorci_top #(
    .CLK_FREQ  (CLK_FREQ),
    .BIT_RATE  (BIT_RATE),
    .MEM_WORDS (MEM_WORDS)
  ) processorci_top_inst (
    .sys_clk  (sys_clk),
    .arst_n_i (arst_n_i),
    .rx_i     (rx_i),
    .tx_o     (tx_o),
    .halted_o (halted_o)
  );

  always #20 sys_clk = ~sys_clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    assert (act === exp)
      else fail_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act));
  endtask

  // Watchdog on the whole run
  always @(posedge sys_clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // Host receiver, samples tx_o at the falling clock edge
  initial begin : tx_monitor
    byte_t data;
    @(posedge arst_n_i);
    forever begin
      @(negedge sys_clk);
      if (tx_o === 1'b0) begin
        // Middle of the start bit
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge sys_clk);
        assert (tx_o === 1'b0)
          else fail_run("The start bit on the tx line did not hold");
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge sys_clk);
          data[i] = tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        assert (tx_o === 1'b1)
          else fail_run("The stop bit on the tx line was low");
        reply_q.push_back(data);
      end
    end
  end

  // Entered and left 5 ns after a rising edge
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx_i = frame[i];
      repeat (CLKS_PER_BIT) @(posedge sys_clk);
      #5;
    end
  endtask

  task automatic recv_byte(output byte_t b);
    while (reply_q.size() == 0) begin
      @(posedge sys_clk);
      #5;
    end
    b = reply_q.pop_front();
  endtask

  task automatic write_word(input waddr_t a, input word_t w);
    send_byte(CMD_WRITE);
    send_byte(a);
    for (int i = 0; i < 4; i++) begin
      send_byte(w[8*i +: 8]);
    end
    model_mem[a % MEM_WORDS] = w;
  endtask

  task automatic read_word(input waddr_t a, output word_t w);
    byte_t b;
    send_byte(CMD_READ);
    send_byte(a);
    for (int i = 0; i < 4; i++) begin
      recv_byte(b);
      w[8*i +: 8] = b;
    end
  endtask

  task automatic read_status(output byte_t s);
    send_byte(CMD_STATUS);
    recv_byte(s);
  endtask

  task automatic wait_halted(input logic level);
    @(negedge sys_clk);
    while (halted_o !== level) begin
      @(negedge sys_clk);
    end
    @(posedge sys_clk);
    #5;
  endtask

  function automatic bit is_command(input byte_t b);
    return b inside {CMD_WRITE, CMD_READ, CMD_START, CMD_HALT, CMD_STATUS};
  endfunction

  // Reference interpreter, applies the program's stores to the model
  task automatic interpret_program();
    waddr_t pc;
    word_t  acc;
    word_t  instr;
    bit     done;
    pc   = '0;
    acc  = '0;
    done = 1'b0;
    for (int step = 0; step < 256 && !done; step++) begin
      instr = model_mem[pc % MEM_WORDS];
      case (instr[31:28])
        OP_LOADI: acc = {24'd0, instr[7:0]};
        OP_ADDI:  acc = acc + {24'd0, instr[7:0]};
        OP_STORE: model_mem[instr[7:0] % MEM_WORDS] = acc;
        OP_HALT:  done = 1'b1;
        default: ;
      endcase
      if (!done) begin
        pc = pc + 1'b1;
      end
    end
  endtask

  task automatic check_stores(input string name);
    word_t w;
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (store_hit[a]) begin
        read_word(waddr_t'(a), w);
        check_value($sformatf("%s addr %0d", name, a), model_mem[a], w);
      end
    end
  endtask

  initial begin
    word_t   w;
    byte_t   s;
    byte_t   junk;
    opcode_t op;
    byte_t   imm;
    sys_clk  = 1'b0;
    arst_n_i = 1'b0;
    rx_i     = 1'b1;
    void'($urandom(28176));
    repeat (5) @(posedge sys_clk);
    #5;
    arst_n_i = 1'b1;

    // After reset: quiet line and a zero status
    for (int i = 0; i < 20; i++) begin
      @(negedge sys_clk);
      check_value("reset tx_o", 32'd1, {31'd0, tx_o});
      check_value("reset halted_o", 32'd0, {31'd0, halted_o});
    end
    @(posedge sys_clk);
    #5;
    check_value("reset no reply", 32'd0, reply_q.size());
    read_status(s);
    check_value("reset status", 32'd0, {24'd0, s});

    // Write and read back
    for (int i = 0; i < NUM_RW; i++) begin
      wr_addr[i] = waddr_t'($urandom_range(0, MEM_WORDS - 1));
      write_word(wr_addr[i], $urandom);
    end
    for (int i = 0; i < NUM_RW; i++) begin
      read_word(wr_addr[i], w);
      check_value($sformatf("readback addr %0d", wr_addr[i]), model_mem[wr_addr[i]], w);
    end

    // Program at 0, stores land in words 32 to 47
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      op  = (i == PROG_LEN - 2) ? OP_STORE : opcode_t'($urandom_range(0, 2));
      imm = (op == OP_STORE) ? byte_t'($urandom_range(32, 47)) : byte_t'($urandom);
      if (op == OP_STORE) begin
        store_hit[imm] = 1'b1;
      end
      write_word(waddr_t'(i), {op, 20'($urandom), imm});
    end
    write_word(waddr_t'(PROG_LEN - 1), {OP_HALT, 20'($urandom), 8'($urandom)});
    send_byte(CMD_START);
    wait_halted(1'b1);
    interpret_program();
    read_status(s);
    check_value("run status", 32'd3, {24'd0, s});
    check_stores("run store");

    // Stop, clobber the results, restart from address 0
    send_byte(CMD_HALT);
    wait_halted(1'b0);
    read_status(s);
    check_value("halt status", 32'd0, {24'd0, s});
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (store_hit[a]) begin
        write_word(waddr_t'(a), $urandom);
      end
    end
    send_byte(CMD_START);
    wait_halted(1'b1);
    interpret_program();
    check_stores("restart store");

    // Non-command byte in idle
    do begin
      junk = byte_t'($urandom);
    end while (is_command(junk));
    send_byte(junk);
    repeat (QUIET_BYTES * 10 * CLKS_PER_BIT) @(posedge sys_clk);
    #5;
    check_value($sformatf("unknown byte 0x%02h reply count", junk), 32'd0, reply_q.size());
    read_word(wr_addr[0], w);
    check_value("read after unknown byte", model_mem[wr_addr[0]], w);

    $display("all tests passed");
    $finish;
  end

endmodule

// File: build.f
hw/pci_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_decoder.sv
hw/prog_memory.sv
hw/acc_core.sv
hw/processorci_top.sv
test/tb_processorci.sv
